//--- sim.f
rtl/sram_pkg.sv
rtl/sram_macro_be.sv
rtl/ram_1p_banked.sv
rtl/sram_axil_req.sv
rtl/sram_axil_rsp.sv
rtl/sram_axil_top.sv
bench/sram_axil_checker.sv
bench/tb_sram_axil.sv

//--- bench/tb_sram_axil.sv
`timescale 1ns/1ns

module tb_sram_axil;
  import sram_pkg::*;

  localparam int depth_words = 1024;
  localparam int bank_depth  = 256;
  localparam int n_trans     = 64 + 5 + 4 + 16 + 200;  // Writes and reads over all tests
  localparam int cycle_limit = 20 * n_trans;

  logic       clk_i, reset_i;
  axil_addr_t awaddr_i, araddr_i;
  axil_data_t wdata_i, rdata_o;
  axil_strb_t wstrb_i;
  axil_resp_t bresp_o, rresp_o;
  logic       awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic       arvalid_i, arready_o, rvalid_o, rready_i;
  integer     stim_seed  = 32'h70d4_07a6;
  integer     ready_seed = 32'h70d4_07a6;  // Own stream for BREADY and RREADY
  int         tests_run  = 0;
  int         tests_ok   = 0;
  int         err_start  = 0;

  sram_axil_top #(
    .depth_words (depth_words),
    .bank_depth  (bank_depth )
  ) UUT (.*);

  sram_axil_checker #(.depth_words(depth_words)) chk (
    .clk_i(clk_i), .reset_i(reset_i),
    .awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_i(awready_o),
    .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_i(wready_o),
    .bresp_i(bresp_o), .bvalid_i(bvalid_o), .bready_i(bready_i),
    .araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_i(arready_o),
    .rdata_i(rdata_o), .rresp_i(rresp_o), .rvalid_i(rvalid_o), .rready_i(rready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    logic [31:0] r;
    {bready_i, rready_i} = 2'b11;
    forever begin
      @(negedge clk_i);
      r        = $random(ready_seed);
      bready_i = |r[1:0];  // High about three cycles in four
      rready_i = |r[3:2];
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, a transaction did not complete", cycles);
    $display("tests failed");
    $finish;
  end

  // Eight words per bank at both ends of each bank
  function automatic axil_addr_t pool_addr(logic [4:0] k);
    int row;
    row = (k[2:0] < 4) ? k[2:0] : bank_depth - 8 + k[2:0];
    return axil_addr_t'((k[4:3] * bank_depth + row) * 4);
  endfunction

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb);
    logic aw_done, w_done;
    @(negedge clk_i);
    awaddr_i = addr;
    wdata_i  = data;
    wstrb_i  = strb;
    {awvalid_i, wvalid_i} = 2'b11;
    while (awvalid_i || wvalid_i) begin
      @(posedge clk_i);
      aw_done = awready_o;
      w_done  = wready_o;
      @(negedge clk_i);
      if (aw_done) awvalid_i = 1'b0;
      if (w_done) wvalid_i = 1'b0;
    end
    @(posedge clk_i);
    while (!(bvalid_o && bready_i)) @(posedge clk_i);
  endtask

  task automatic axi_read(input axil_addr_t addr);
    @(negedge clk_i);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    @(posedge clk_i);
    while (!arready_o) @(posedge clk_i);
    @(negedge clk_i);
    arvalid_i = 1'b0;
    @(posedge clk_i);
    while (!(rvalid_o && rready_i)) @(posedge clk_i);
  endtask

  task automatic close_test(input string next_name);
    int n;
    @(negedge clk_i);
    n = chk.errors - err_start;
    if (n == 0) $display("%s: ok", chk.cur_test);
    else $display("%s: %0d errors", chk.cur_test, n);
    tests_ok += (n == 0);
    tests_run++;
    chk.cur_test = next_name;
    err_start    = chk.errors;
  endtask

  initial begin
    logic [31:0] r, d;
    axil_addr_t  addr;
    {awvalid_i, wvalid_i, arvalid_i} = 3'b000;
    awaddr_i = '0;
    araddr_i = '0;
    wdata_i  = '0;
    wstrb_i  = '0;
    reset_i  = 1'b1;
    repeat (5) @(negedge clk_i);
    chk.compare_value("bvalid", 0, bvalid_o);
    chk.compare_value("rvalid", 0, rvalid_o);
    chk.compare_value("ready", 3'b000, {awready_o, wready_o, arready_o});  // Nothing taken
    reset_i = 1'b0;
    close_test("all banks");
    for (int k = 0; k < 32; k++) begin
      axi_write(pool_addr(k), 32'h9e37_79b9 * (pool_addr(k) + 1), 4'hf);
    end
    for (int k = 0; k < 32; k++) axi_read(pool_addr(k));
    close_test("partial strobes");
    axi_write(pool_addr(5), 32'h1122_3344, 4'hf);
    axi_write(pool_addr(5), 32'haabb_ccdd, 4'b0101);
    axi_read(pool_addr(5));
    axi_write(pool_addr(5), 32'hee00_0000, 4'b1000);
    axi_read(pool_addr(5));
    close_test("out of range");
    axi_write(32'h0000_1000, 32'hdead_beef, 4'hf);  // Low bits alias word 0
    axi_write(32'h8000_0000, 32'hdead_beef, 4'hf);
    axi_read(32'h0000_1004);
    axi_read(pool_addr(0));
    close_test("write and read together");
    for (int k = 0; k < 8; k++) begin
      r = $random(stim_seed);
      d = $random(stim_seed);
      fork
        axi_write(pool_addr(r[4:0]), d, r[8:5]);
        axi_read(pool_addr(r[13:9]));
      join
    end
    close_test("random mix");
    for (int k = 0; k < 200; k++) begin
      r    = $random(stim_seed);
      d    = $random(stim_seed);
      addr = (r[3:0] == 0) ? 32'h1000 + {r[31:20], 2'b00} : pool_addr(r[8:4]);
      if (r[9]) axi_write(addr, d, r[13:10]);
      else axi_read(addr);
    end
    close_test("");
    $display("%0d tests run, %0d ok, %0d checks, %0d errors",
             tests_run, tests_ok, chk.checks, chk.errors);
    if (tests_ok == tests_run && chk.errors == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

//--- bench/sram_axil_checker.sv
`timescale 1ns/1ns

module sram_axil_checker #(
  parameter int depth_words = 1024
) (
  input logic                 clk_i,
  input logic                 reset_i,
  input sram_pkg::axil_addr_t awaddr_i,
  input logic                 awvalid_i, awready_i,
  input sram_pkg::axil_data_t wdata_i,
  input sram_pkg::axil_strb_t wstrb_i,
  input logic                 wvalid_i, wready_i,
  input sram_pkg::axil_resp_t bresp_i,
  input logic                 bvalid_i, bready_i,
  input sram_pkg::axil_addr_t araddr_i,
  input logic                 arvalid_i, arready_i,
  input sram_pkg::axil_data_t rdata_i,
  input sram_pkg::axil_resp_t rresp_i,
  input logic                 rvalid_i, rready_i
);
  import sram_pkg::*;

  axil_data_t shadow [depth_words];  // Expected memory contents
  axil_addr_t aw_addr;
  axil_addr_t ar_addr;
  axil_data_t w_data;
  axil_strb_t w_strb;
  logic       b_held;                // Valid without ready at the last edge
  logic       r_held;
  axil_resp_t b_last;
  axil_resp_t r_last_resp;
  axil_data_t r_last_data;
  string      cur_test = "reset state";
  int         errors   = 0;
  int         checks   = 0;

  // Bytes with a strobe take the new data
  function automatic axil_data_t merge_bytes(axil_data_t old, axil_data_t data,
                                             axil_strb_t strb);
    axil_data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic in_range(axil_addr_t addr);
    return addr < depth_words * 4;
  endfunction

  function automatic axil_resp_t expected_resp(axil_addr_t addr);
    return in_range(addr) ? resp_okay : resp_slverr;
  endfunction

  function automatic axil_data_t expected_rdata(axil_addr_t addr);
    return in_range(addr) ? shadow[addr >> 2] : '0;  // Error reads return zero
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("%s: %s", cur_test, what);
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (b_held && !bvalid_i) report_fault("BVALID dropped before BREADY");
      else if (b_held) compare_value("bresp hold", b_last, bresp_i);
      if (r_held && !rvalid_i) report_fault("RVALID dropped before RREADY");
      else if (r_held) begin
        compare_value("rdata hold", r_last_data, rdata_i);
        compare_value("rresp hold", r_last_resp, rresp_i);
      end
      if (awvalid_i && awready_i) aw_addr = awaddr_i;
      if (arvalid_i && arready_i) ar_addr = araddr_i;
      if (wvalid_i && wready_i) begin
        w_data = wdata_i;
        w_strb = wstrb_i;
      end
      // Responses come back in execution order, one at a time
      if (bvalid_i && bready_i) begin
        compare_value("bresp", expected_resp(aw_addr), bresp_i);
        if (in_range(aw_addr)) begin
          shadow[aw_addr >> 2] = merge_bytes(shadow[aw_addr >> 2], w_data, w_strb);
        end
      end
      if (rvalid_i && rready_i) begin
        compare_value("rdata", expected_rdata(ar_addr), rdata_i);
        compare_value("rresp", expected_resp(ar_addr), rresp_i);
      end
      b_held      = bvalid_i && !bready_i;
      b_last      = bresp_i;
      r_held      = rvalid_i && !rready_i;
      r_last_data = rdata_i;
      r_last_resp = rresp_i;
    end else begin
      b_held = 1'b0;
      r_held = 1'b0;
    end
  end

endmodule

//--- rtl/sram_axil_top.sv
`timescale 1ns/1ns

module sram_axil_top #(
  parameter int depth_words = 1024,
  parameter int bank_depth  = 256
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  sram_pkg::axil_addr_t awaddr_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  sram_pkg::axil_data_t wdata_i,
  input  sram_pkg::axil_strb_t wstrb_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output sram_pkg::axil_resp_t bresp_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  input  sram_pkg::axil_addr_t araddr_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output sram_pkg::axil_data_t rdata_o,
  output sram_pkg::axil_resp_t rresp_o,
  output logic                 rvalid_o,
  input  logic                 rready_i
);
  import sram_pkg::*;

  localparam int aw = $clog2(depth_words);

  logic          ram_req;
  logic          ram_write;
  logic [aw-1:0] ram_addr;     // Word address
  axil_data_t    ram_wdata;
  axil_data_t    ram_wmask;    // Bit mask from strobes
  axil_data_t    ram_rdata;
  logic          rsp_start;
  logic          rsp_is_write;
  logic          rsp_err;
  logic          rsp_busy;

  sram_axil_req #(
    .depth_words (depth_words)
  ) u_req (
    .clk_i          (clk_i       ),
    .reset_i        (reset_i     ),
    .awaddr_i       (awaddr_i    ),
    .awvalid_i      (awvalid_i   ),
    .awready_o      (awready_o   ),
    .wdata_i        (wdata_i     ),
    .wstrb_i        (wstrb_i     ),
    .wvalid_i       (wvalid_i    ),
    .wready_o       (wready_o    ),
    .araddr_i       (araddr_i    ),
    .arvalid_i      (arvalid_i   ),
    .arready_o      (arready_o   ),
    .rsp_busy_i     (rsp_busy    ),
    .ram_req_o      (ram_req     ),
    .ram_write_o    (ram_write   ),
    .ram_addr_o     (ram_addr    ),
    .ram_wdata_o    (ram_wdata   ),
    .ram_wmask_o    (ram_wmask   ),
    .rsp_start_o    (rsp_start   ),
    .rsp_is_write_o (rsp_is_write),
    .rsp_err_o      (rsp_err     )
  );

  ram_1p_banked #(
    .depth_words (depth_words),
    .bank_depth  (bank_depth )
  ) u_ram (
    .clk_i   (clk_i    ),
    .req_i   (ram_req  ),
    .write_i (ram_write),
    .addr_i  (ram_addr ),
    .wdata_i (ram_wdata),
    .wmask_i (ram_wmask),
    .rdata_o (ram_rdata)
  );

  sram_axil_rsp u_rsp (
    .clk_i          (clk_i       ),
    .reset_i        (reset_i     ),
    .rsp_start_i    (rsp_start   ),
    .rsp_is_write_i (rsp_is_write),
    .rsp_err_i      (rsp_err     ),
    .ram_rdata_i    (ram_rdata   ),
    .bvalid_o       (bvalid_o    ),
    .bresp_o        (bresp_o     ),
    .bready_i       (bready_i    ),
    .rvalid_o       (rvalid_o    ),
    .rdata_o        (rdata_o     ),
    .rresp_o        (rresp_o     ),
    .rready_i       (rready_i    ),
    .rsp_busy_o     (rsp_busy    )
  );

endmodule

//--- rtl/sram_axil_rsp.sv
`timescale 1ns/1ns

module sram_axil_rsp (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 rsp_start_i,
  input  logic                 rsp_is_write_i,
  input  logic                 rsp_err_i,
  input  sram_pkg::axil_data_t ram_rdata_i,
  output logic                 bvalid_o,
  output sram_pkg::axil_resp_t bresp_o,
  input  logic                 bready_i,
  output logic                 rvalid_o,
  output sram_pkg::axil_data_t rdata_o,
  output sram_pkg::axil_resp_t rresp_o,
  input  logic                 rready_i,
  output logic                 rsp_busy_o
);
  import sram_pkg::*;

  typedef enum logic [1:0] {
    rd_idle,
    rd_read_wait,  // RAM data arrives this cycle
    rd_hold
  } rd_state_e;

  rd_state_e  rd_state_q;
  logic       bvalid_q;
  logic       rd_err_q;
  axil_resp_t bresp_q;
  axil_resp_t rresp_q;
  axil_data_t rdata_q;
  axil_data_t rdata_now;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q   <= 1'b0;
      rd_state_q <= rd_idle;
    end else begin
      if (rsp_start_i && rsp_is_write_i) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      case (rd_state_q)
        rd_idle: if (rsp_start_i && !rsp_is_write_i) rd_state_q <= rd_read_wait;
        rd_read_wait: rd_state_q <= rready_i ? rd_idle : rd_hold;
        rd_hold: if (rready_i) rd_state_q <= rd_idle;
        default: rd_state_q <= rd_idle;
      endcase
    end
  end

  // Error reads return zero
  assign rdata_now = rd_err_q ? '0 : ram_rdata_i;

  always_ff @(posedge clk_i) begin
    if (rsp_start_i) begin
      rd_err_q <= rsp_err_i;
      if (rsp_is_write_i) begin
        bresp_q <= rsp_err_i ? resp_slverr : resp_okay;
      end else begin
        rresp_q <= rsp_err_i ? resp_slverr : resp_okay;
      end
    end
    if (rd_state_q == rd_read_wait) begin
      rdata_q <= rdata_now;
    end
  end

  assign bvalid_o   = bvalid_q;
  assign bresp_o    = bresp_q;
  assign rvalid_o   = (rd_state_q != rd_idle);
  assign rdata_o    = (rd_state_q == rd_read_wait) ? rdata_now : rdata_q;
  assign rresp_o    = rresp_q;
  assign rsp_busy_o = bvalid_q | (rd_state_q != rd_idle);

  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("B response dropped before BREADY");

  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else $error("R response dropped before RREADY");

endmodule

//--- rtl/sram_axil_req.sv
`timescale 1ns/1ns

module sram_axil_req #(
  parameter  int depth_words = 1024,
  localparam int aw          = $clog2(depth_words)
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  sram_pkg::axil_addr_t awaddr_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  sram_pkg::axil_data_t wdata_i,
  input  sram_pkg::axil_strb_t wstrb_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  sram_pkg::axil_addr_t araddr_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  input  logic                 rsp_busy_i,
  output logic                 ram_req_o,
  output logic                 ram_write_o,
  output logic [aw-1:0]        ram_addr_o,
  output sram_pkg::axil_data_t ram_wdata_o,
  output sram_pkg::axil_data_t ram_wmask_o,
  output logic                 rsp_start_o,
  output logic                 rsp_is_write_o,
  output logic                 rsp_err_o
);
  import sram_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait_rsp
  } state_e;

  state_e     state_q;
  logic       aw_full_q;     // AW captured
  logic       w_full_q;      // W captured
  logic       ar_full_q;     // AR captured
  logic       op_write_q;    // Kind of the issued transaction
  logic       prio_write_q;  // Write wins the next conflict
  axil_addr_t awaddr_q;
  axil_addr_t araddr_q;
  axil_data_t wdata_q;
  axil_strb_t wstrb_q;

  logic       aw_hs;
  logic       w_hs;
  logic       ar_hs;
  logic       wr_pend;
  logic       rd_pend;
  logic       pick_write;
  axil_addr_t sel_addr;
  logic       sel_err;

  // Held low in reset
  assign awready_o = ~reset_i & (state_q == st_idle) & ~aw_full_q & ~rsp_busy_i;
  assign wready_o  = ~reset_i & (state_q == st_idle) & ~w_full_q & ~rsp_busy_i;
  assign arready_o = ~reset_i & (state_q == st_idle) & ~ar_full_q & ~rsp_busy_i;

  assign aw_hs = awvalid_i & awready_o;
  assign w_hs  = wvalid_i & wready_o;
  assign ar_hs = arvalid_i & arready_o;

  // Pending work including handshakes in this cycle
  assign wr_pend    = (aw_full_q | aw_hs) & (w_full_q | w_hs);
  assign rd_pend    = ar_full_q | ar_hs;
  assign pick_write = wr_pend & (~rd_pend | prio_write_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= st_idle;
      aw_full_q    <= 1'b0;
      w_full_q     <= 1'b0;
      ar_full_q    <= 1'b0;
      op_write_q   <= 1'b0;
      prio_write_q <= 1'b1;  // Writes first after reset
    end else begin
      case (state_q)
        st_idle: begin
          if (aw_hs) aw_full_q <= 1'b1;
          if (w_hs)  w_full_q  <= 1'b1;
          if (ar_hs) ar_full_q <= 1'b1;
          if (wr_pend | rd_pend) begin
            op_write_q <= pick_write;
            if (wr_pend & rd_pend) begin
              prio_write_q <= ~pick_write;  // Other kind wins next time
            end
            state_q <= st_issue;
          end
        end
        st_issue: begin
          if (op_write_q) begin
            aw_full_q <= 1'b0;
            w_full_q  <= 1'b0;
          end else begin
            ar_full_q <= 1'b0;
          end
          state_q <= st_wait_rsp;
        end
        st_wait_rsp: begin
          if (!rsp_busy_i) state_q <= st_idle;  // Response has been taken
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) awaddr_q <= awaddr_i;
    if (ar_hs) araddr_q <= araddr_i;
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  assign sel_addr = op_write_q ? awaddr_q : araddr_q;
  assign sel_err  = (sel_addr >= axil_addr_t'(depth_words * 4));

  assign ram_req_o      = (state_q == st_issue) & ~sel_err;  // No RAM access on error
  assign ram_write_o    = op_write_q;
  assign ram_addr_o     = sel_addr[aw+1:2];                  // Byte to word address
  assign ram_wdata_o    = wdata_q;
  assign rsp_start_o    = (state_q == st_issue);
  assign rsp_is_write_o = op_write_q;
  assign rsp_err_o      = sel_err;

  for (genvar i = 0; i < $bits(axil_strb_t); i++) begin : g_mask
    assign ram_wmask_o[8*i +: 8] = {8{wstrb_q[i]}};  // Strobe to byte mask
  end

  a_req_not_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ram_req_o) |-> !rsp_busy_i)
    else $error("RAM request issued while a response is outstanding");

endmodule

//--- rtl/ram_1p_banked.sv
`timescale 1ns/1ns

module ram_1p_banked #(
  parameter  int depth_words = 1024,
  parameter  int bank_depth  = 256,
  localparam int aw          = $clog2(depth_words)
) (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 write_i,
  input  logic [aw-1:0]        addr_i,
  input  sram_pkg::axil_data_t wdata_i,
  input  sram_pkg::axil_data_t wmask_i,
  output sram_pkg::axil_data_t rdata_o   // Valid one cycle after req_i
);
  import sram_pkg::*;

  localparam int num_banks = depth_words / bank_depth;
  localparam int bw        = $clog2(bank_depth);
  localparam int iw        = (num_banks > 1) ? $clog2(num_banks) : 1;

  logic [iw-1:0]        bank_idx;
  logic [iw-1:0]        bank_idx_q;  // Bank of the last request
  logic [bw-1:0]        row;
  logic [num_banks-1:0] ren_bank;
  logic [num_banks-1:0] wen_bank;
  axil_data_t           wbeb_bank  [num_banks];
  axil_data_t           rdata_bank [num_banks];

  assign bank_idx = iw'(addr_i >> bw);  // Upper address bits pick the bank
  assign row      = addr_i[bw-1:0];

  for (genvar k = 0; k < num_banks; k++) begin : g_bank
    logic sel;

    assign sel          = (bank_idx == k);
    assign ren_bank[k]  = sel & req_i & ~write_i;
    assign wen_bank[k]  = sel & req_i & write_i;
    assign wbeb_bank[k] = sel ? ~wmask_i : '1;  // Unselected banks write nothing

    sram_macro_be #(
      .depth (bank_depth)
    ) u_sram (
      .clk_i  (clk_i        ),
      .ren_i  (ren_bank[k]  ),
      .wen_i  (wen_bank[k]  ),
      .adr_i  (row          ),
      .din_i  (wdata_i      ),
      .wbeb_i (wbeb_bank[k] ),
      .q_o    (rdata_bank[k])
    );
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_idx_q <= bank_idx;
    end
  end

  assign rdata_o = rdata_bank[bank_idx_q];  // Mux follows the registered bank

  a_one_bank: assert property (@(posedge clk_i) $onehot0(ren_bank | wen_bank))
    else $error("more than one SRAM bank enabled");

endmodule

//--- rtl/sram_macro_be.sv
`timescale 1ns/1ns

module sram_macro_be #(
  parameter  int depth = 256,
  localparam int aw    = $clog2(depth)
) (
  input  logic                 clk_i,
  input  logic                 ren_i,   // Read enable
  input  logic                 wen_i,   // Write enable
  input  logic [aw-1:0]        adr_i,
  input  sram_pkg::axil_data_t din_i,
  input  sram_pkg::axil_data_t wbeb_i,  // Bit write enable, active low
  output sram_pkg::axil_data_t q_o
);
  import sram_pkg::*;

  axil_data_t mem [depth];

  // Only bits with wbeb low take the new value
  always_ff @(posedge clk_i) begin
    if (wen_i) begin
      mem[adr_i] <= (mem[adr_i] & wbeb_i) | (din_i & ~wbeb_i);
    end
  end

  // Read data registered, held between reads
  always_ff @(posedge clk_i) begin
    if (ren_i) begin
      q_o <= mem[adr_i];
    end
  end

endmodule

//--- rtl/sram_pkg.sv
package sram_pkg;

  // AXI4-Lite bus fields, 32-bit data only
  typedef logic [31:0] axil_addr_t;  // Byte address
  typedef logic [31:0] axil_data_t;  // Data word
  typedef logic [3:0]  axil_strb_t;  // One strobe per byte lane
  typedef logic [1:0]  axil_resp_t;  // B and R response code

  // Response codes
  localparam axil_resp_t resp_okay   = 2'b00;
  localparam axil_resp_t resp_slverr = 2'b10;

endpackage
